/* logic/wbh_pkg.sv */
package wbh_pkg;

   // --------------------
   // bus payloads
   // --------------------

   // request as seen on the slave bus
   typedef struct packed {
      logic [31:0] adr;
      logic        we;
      logic [31:0] dat;
      logic [3:0]  sel;
   } wbh_req_t;

   // response returned to the master
   typedef struct packed {
      logic [31:0] dat;
      logic        ack;
      logic        err;
   } wbh_rsp_t;

   // --------------------
   // master address views
   // --------------------

   // local register window view
   typedef struct packed {
      logic [7:0]  top;
      logic        win;
      logic [18:0] rsvd;
      logic [1:0]  idx;
      logic [1:0]  lsb;
   } wbh_adr_reg_t;

   // bridge view, top byte replaced by bank
   typedef struct packed {
      logic [7:0]  top;
      logic [23:0] ofs;
   } wbh_adr_brg_t;

   typedef union packed {
      wbh_adr_reg_t regs;
      wbh_adr_brg_t brg;
   } wbh_adr_u;

   // global control word, 11 bits
   typedef struct packed {
      logic       div_en;
      logic [1:0] ratio;
      logic [7:0] glb_ctrl;
   } wbh_glb_t;

   // register indices, address bits 3:2
   localparam logic [1:0] REG_GLB  = 2'd0;
   localparam logic [1:0] REG_BANK = 2'd1;
   localparam logic [1:0] REG_CLK1 = 2'd2;
   localparam logic [1:0] REG_CLK2 = 2'd3;

   // bank value after reset
   localparam logic [7:0] BANK_RST = 8'h30;

endpackage

/* logic/wbh_ctrl_regs.sv */
`timescale 1ns/1ps

module wbh_ctrl_regs (
   input  logic              wbm_clk_i,
   input  logic              wbm_rst_n,
   input  logic              sel_i,
   input  logic              we_i,
   input  logic [1:0]        idx_i,
   input  logic [31:0]       dat_i,
   output logic [31:0]       rdata_o,
   output logic              ack_o,
   output wbh_pkg::wbh_glb_t glb_o,
   output logic [7:0]        bank_o,
   output logic [31:0]       clk_ctrl1_o,
   output logic [31:0]       clk_ctrl2_o
);

   import wbh_pkg::*;

   logic        ack_q;
   logic        acc_en;
   logic        wr_en;
   logic [31:0] rd_mux;
   wbh_glb_t    glb_q;
   logic [7:0]  bank_q;
   logic [31:0] clk1_q;
   logic [31:0] clk2_q;

   // new access only while no ack is out
   assign acc_en = sel_i & ~ack_q;
   assign wr_en  = acc_en & we_i;

   // --------------------
   // acknowledge
   // --------------------

   // one pulse per access, low for a cycle between
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         ack_q <= 1'b0;
      else
         ack_q <= acc_en;
   end

   // --------------------
   // register file
   // --------------------

   // writes land on the same edge that raises ack
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_q  <= '0;
         bank_q <= BANK_RST;
         clk1_q <= '0;
         clk2_q <= '0;
      end
      else if (wr_en)
      begin
         case (idx_i)
            REG_GLB:  glb_q  <= wbh_glb_t'(dat_i[10:0]);
            REG_BANK: bank_q <= dat_i[7:0];
            REG_CLK1: clk1_q <= dat_i;
            REG_CLK2: clk2_q <= dat_i;
            default:  clk2_q <= clk2_q;
         endcase
      end
   end

   // readback mux, unused bits zero
   always_comb
   begin
      rd_mux = '0;
      case (idx_i)
         REG_GLB:  rd_mux = {21'h0, glb_q};
         REG_BANK: rd_mux = {24'h0, bank_q};
         REG_CLK1: rd_mux = clk1_q;
         REG_CLK2: rd_mux = clk2_q;
         default:  rd_mux = '0;
      endcase
   end

   // read data held while ack is high
   always_ff @(posedge wbm_clk_i)
   begin
      if (acc_en && !we_i)
         rdata_o <= rd_mux;
   end

   assign ack_o       = ack_q;
   assign glb_o       = glb_q;
   assign bank_o      = bank_q;
   assign clk_ctrl1_o = clk1_q;
   assign clk_ctrl2_o = clk2_q;

endmodule

/* logic/wbh_slave_clk_gen.sv */
`timescale 1ns/1ps

module wbh_slave_clk_gen (
   input  logic       wbm_clk_i,
   input  logic       wbm_rst_n,
   input  logic       div_en_i,
   input  logic [1:0] ratio_i,
   output logic       wbs_clk_o
);

   logic [1:0] cnt_q;
   logic       clk_div_q;

   // --------------------
   // divider
   // --------------------

   // toggle every ratio+1 master cycles
   // period is 2*(ratio+1) master cycles
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         cnt_q     <= '0;
         clk_div_q <= 1'b0;
      end
      else if (!div_en_i)
      begin
         // parked low so the first high phase is full length
         cnt_q     <= '0;
         clk_div_q <= 1'b0;
      end
      else if (cnt_q >= ratio_i)
      begin
         // >= covers a ratio lowered mid count
         cnt_q     <= '0;
         clk_div_q <= ~clk_div_q;
      end
      else
      begin
         cnt_q <= cnt_q + 2'd1;
      end
   end

   // clock select, master clock when divider is off
   assign wbs_clk_o = div_en_i ? clk_div_q : wbm_clk_i;

endmodule

/* logic/wbh_async_bridge.sv */
`timescale 1ns/1ps

module wbh_async_bridge #(
   parameter int SYNC_STAGES = 2
) (
   // master domain
   input  logic              wbm_clk_i,
   input  logic              wbm_rst_n,
   input  logic              stb_i,
   input  wbh_pkg::wbh_req_t req_i,
   output wbh_pkg::wbh_rsp_t rsp_o,
   // slave domain
   input  logic              wbs_clk_i,
   output logic              wbs_cyc_o,
   output logic              wbs_stb_o,
   output wbh_pkg::wbh_req_t wbs_req_o,
   input  logic [31:0]       wbs_dat_i,
   input  logic              wbs_ack_i,
   input  logic              wbs_err_i
);

   import wbh_pkg::*;

   // master side state
   wbh_req_t               m_req_q;
   logic                   m_start;
   logic                   m_busy_q;
   logic                   m_req_tgl_q;
   logic [SYNC_STAGES-1:0] m_rsp_sync_q;
   logic                   m_rsp_seen_q;
   logic                   m_rsp_evt;
   logic [31:0]            m_dat_q;
   logic                   m_ack_q;
   logic                   m_err_q;

   // slave side state
   logic [SYNC_STAGES-1:0] s_rst_sync_q;
   logic                   s_rst_n;
   logic [SYNC_STAGES-1:0] s_req_sync_q;
   logic                   s_req_seen_q;
   logic                   s_req_evt;
   logic                   s_cyc_q;
   logic                   s_done;
   logic                   s_rsp_tgl_q;
   logic [31:0]            s_dat_q;
   logic                   s_err_q;

   // --------------------
   // master side
   // --------------------

   // no capture while open or while the reply pulse is out
   // so a held stb is not taken twice
   assign m_start = stb_i & ~m_busy_q & ~m_ack_q & ~m_err_q;

   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         m_busy_q    <= 1'b0;
         m_req_tgl_q <= 1'b0;
      end
      else if (m_start)
      begin
         m_busy_q    <= 1'b1;
         m_req_tgl_q <= ~m_req_tgl_q;
      end
      else if (m_rsp_evt)
      begin
         m_busy_q <= 1'b0;
      end
   end

   // request held stable for the whole crossing
   always_ff @(posedge wbm_clk_i)
   begin
      if (m_start)
         m_req_q <= req_i;
   end

   // response toggle back into master clock
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         m_rsp_sync_q <= '0;
         m_rsp_seen_q <= 1'b0;
         m_ack_q      <= 1'b0;
         m_err_q      <= 1'b0;
      end
      else
      begin
         m_rsp_sync_q <= {m_rsp_sync_q[SYNC_STAGES-2:0], s_rsp_tgl_q};
         m_rsp_seen_q <= m_rsp_sync_q[SYNC_STAGES-1];
         // one cycle pulse, err wins over ack
         m_ack_q      <= m_rsp_evt & ~s_err_q;
         m_err_q      <= m_rsp_evt & s_err_q;
      end
   end

   assign m_rsp_evt = m_rsp_sync_q[SYNC_STAGES-1] ^ m_rsp_seen_q;

   // slave data already settled when the toggle arrives
   always_ff @(posedge wbm_clk_i)
   begin
      if (m_rsp_evt)
         m_dat_q <= s_dat_q;
   end

   assign rsp_o = wbh_rsp_t'{dat: m_dat_q, ack: m_ack_q, err: m_err_q};

   // --------------------
   // slave side
   // --------------------

   // reset asserts at once, releases on wbs_clk_i
   always_ff @(posedge wbs_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         s_rst_sync_q <= '0;
      else
         s_rst_sync_q <= {s_rst_sync_q[SYNC_STAGES-2:0], 1'b1};
   end

   assign s_rst_n = s_rst_sync_q[SYNC_STAGES-1];

   assign s_req_evt = s_req_sync_q[SYNC_STAGES-1] ^ s_req_seen_q;
   assign s_done    = s_cyc_q & (wbs_ack_i | wbs_err_i);

   // bus held until ack or err, dropped on the next edge
   always_ff @(posedge wbs_clk_i or negedge s_rst_n)
   begin
      if (!s_rst_n)
      begin
         s_req_sync_q <= '0;
         s_req_seen_q <= 1'b0;
         s_cyc_q      <= 1'b0;
         s_rsp_tgl_q  <= 1'b0;
      end
      else
      begin
         s_req_sync_q <= {s_req_sync_q[SYNC_STAGES-2:0], m_req_tgl_q};
         if (s_req_evt && !s_cyc_q)
         begin
            s_cyc_q      <= 1'b1;
            s_req_seen_q <= s_req_sync_q[SYNC_STAGES-1];
         end
         else if (s_done)
         begin
            s_cyc_q     <= 1'b0;
            s_rsp_tgl_q <= ~s_rsp_tgl_q;
         end
      end
   end

   // reply latched with the toggle flip
   always_ff @(posedge wbs_clk_i)
   begin
      if (s_done)
      begin
         s_dat_q <= wbs_dat_i;
         s_err_q <= wbs_err_i;
      end
   end

   assign wbs_cyc_o = s_cyc_q;
   assign wbs_stb_o = s_cyc_q;
   assign wbs_req_o = m_req_q;

endmodule

/* logic/wbh_top.sv */
`timescale 1ns/1ps

module wbh_top #(
   parameter int SYNC_STAGES = 2
) (
   // master port
   input  logic        wbm_clk_i,
   input  logic        wbm_rst_n,
   input  logic        wbm_cyc_i,
   input  logic        wbm_stb_i,
   input  logic [31:0] wbm_adr_i,
   input  logic        wbm_we_i,
   input  logic [31:0] wbm_dat_i,
   input  logic [3:0]  wbm_sel_i,
   output logic [31:0] wbm_dat_o,
   output logic        wbm_ack_o,
   output logic        wbm_err_o,
   // slave clock, looped back outside
   output logic        wbs_clk_o,
   input  logic        wbs_clk_i,
   // slave port
   output logic        wbs_cyc_o,
   output logic        wbs_stb_o,
   output logic [31:0] wbs_adr_o,
   output logic        wbs_we_o,
   output logic [31:0] wbs_dat_o,
   output logic [3:0]  wbs_sel_o,
   input  logic [31:0] wbs_dat_i,
   input  logic        wbs_ack_i,
   input  logic        wbs_err_i,
   // configuration
   output logic [7:0]  cfg_glb_ctrl_o,
   output logic [31:0] cfg_clk_ctrl1_o,
   output logic [31:0] cfg_clk_ctrl2_o
);

   import wbh_pkg::*;

   wbh_adr_u    adr_u;
   logic        win;
   logic        loc_stb;
   logic        brg_stb;
   logic [31:0] reg_rdata;
   logic        reg_ack;
   wbh_glb_t    glb;
   logic [7:0]  bank;
   wbh_req_t    brg_req;
   wbh_rsp_t    brg_rsp;
   wbh_req_t    wbs_req;

   // --------------------
   // address decode
   // --------------------

   // bit 23 picks the local window
   assign adr_u   = wbm_adr_i;
   assign win     = adr_u.regs.win;
   assign loc_stb = wbm_cyc_i & wbm_stb_i & win;
   assign brg_stb = wbm_cyc_i & wbm_stb_i & ~win;

   // top byte swapped for the bank register
   assign brg_req = wbh_req_t'{adr: {bank, adr_u.brg.ofs}, we: wbm_we_i,
                               dat: wbm_dat_i, sel: wbm_sel_i};

   // response merge, local path never errs
   assign wbm_dat_o = win ? reg_rdata : brg_rsp.dat;
   assign wbm_ack_o = win ? reg_ack : brg_rsp.ack;
   assign wbm_err_o = win ? 1'b0 : brg_rsp.err;

   // --------------------
   // instances
   // --------------------

   wbh_ctrl_regs i_ctrl_regs (
      .wbm_clk_i   (wbm_clk_i),
      .wbm_rst_n   (wbm_rst_n),
      .sel_i       (loc_stb),
      .we_i        (wbm_we_i),
      .idx_i       (adr_u.regs.idx),
      .dat_i       (wbm_dat_i),
      .rdata_o     (reg_rdata),
      .ack_o       (reg_ack),
      .glb_o       (glb),
      .bank_o      (bank),
      .clk_ctrl1_o (cfg_clk_ctrl1_o),
      .clk_ctrl2_o (cfg_clk_ctrl2_o)
   );

   wbh_slave_clk_gen i_slave_clk_gen (
      .wbm_clk_i (wbm_clk_i),
      .wbm_rst_n (wbm_rst_n),
      .div_en_i  (glb.div_en),
      .ratio_i   (glb.ratio),
      .wbs_clk_o (wbs_clk_o)
   );

   wbh_async_bridge #(
      .SYNC_STAGES (SYNC_STAGES)
   ) i_async_bridge (
      .wbm_clk_i (wbm_clk_i),
      .wbm_rst_n (wbm_rst_n),
      .stb_i     (brg_stb),
      .req_i     (brg_req),
      .rsp_o     (brg_rsp),
      .wbs_clk_i (wbs_clk_i),
      .wbs_cyc_o (wbs_cyc_o),
      .wbs_stb_o (wbs_stb_o),
      .wbs_req_o (wbs_req),
      .wbs_dat_i (wbs_dat_i),
      .wbs_ack_i (wbs_ack_i),
      .wbs_err_i (wbs_err_i)
   );

   // slave bus fields
   assign wbs_adr_o = wbs_req.adr;
   assign wbs_we_o  = wbs_req.we;
   assign wbs_dat_o = wbs_req.dat;
   assign wbs_sel_o = wbs_req.sel;

   assign cfg_glb_ctrl_o = glb.glb_ctrl;

endmodule

/* dv/wbh_top_asserts.sv */
`timescale 1ns/1ps

module wbh_top_asserts (
   input logic        wbm_clk_i,
   input logic        wbm_rst_n,
   input logic        wbm_cyc_i,
   input logic        wbm_stb_i,
   input logic [31:0] wbm_adr_i,
   input logic        wbm_ack_o,
   input logic        wbm_err_o,
   input logic        wbs_clk_i,
   input logic        wbs_cyc_o,
   input logic        wbs_stb_o,
   input logic [31:0] wbs_adr_o,
   input logic        wbs_ack_i,
   input logic        wbs_err_i
);

   // failures seen so far, read by the testbench
   int unsigned fail_cnt = 0;
   logic        loc_stb;

   // strobe into the local window
   assign loc_stb = wbm_cyc_i & wbm_stb_i & wbm_adr_i[23];

   // --------------------
   // master side
   // --------------------

   a_ack_err_excl: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      !(wbm_ack_o && wbm_err_o))
   else
   begin
      $error("ack and err high in the same cycle");
      fail_cnt++;
   end

   // local ack is a single cycle pulse
   a_loc_ack_len: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      wbm_ack_o && wbm_adr_i[23] |=> !wbm_ack_o)
   else
   begin
      $error("local ack longer than one cycle");
      fail_cnt++;
   end

   a_loc_ack_lat: assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      $rose(loc_stb) |=> wbm_ack_o)
   else
   begin
      $error("local ack not one cycle after stb");
      fail_cnt++;
   end

   // --------------------
   // slave side
   // --------------------

   // stb and address held until the slave answers
   a_wbs_hold: assert property (@(posedge wbs_clk_i) disable iff (!wbm_rst_n)
      wbs_stb_o && !(wbs_ack_i || wbs_err_i) |=> wbs_stb_o && $stable(wbs_adr_o))
   else
   begin
      $error("slave stb dropped or address moved before ack");
      fail_cnt++;
   end

   a_rst_idle: assert property (@(posedge wbm_clk_i)
      !wbm_rst_n |-> !wbs_cyc_o && !wbs_stb_o)
   else
   begin
      $error("slave cyc or stb high during reset");
      fail_cnt++;
   end

endmodule

/* dv/tb_wbh_top.sv */
`timescale 1ns/1ps

module tb_wbh_top;

   import wbh_pkg::*;

   // watchdog budget in master cycles
   localparam int N_TESTS        = 6;
   localparam int XFERS_PER_TEST = 40;
   localparam int CYC_PER_XFER   = 400;

   // dut connections
   logic        wbm_clk_i = 1'b0;
   logic        wbm_rst_n;
   logic        wbm_cyc_i;
   logic        wbm_stb_i;
   logic [31:0] wbm_adr_i;
   logic        wbm_we_i;
   logic [31:0] wbm_dat_i;
   logic [3:0]  wbm_sel_i;
   logic [31:0] wbm_dat_o;
   logic        wbm_ack_o;
   logic        wbm_err_o;
   logic        wbs_clk_o;
   logic        wbs_clk_i;
   logic        wbs_cyc_o;
   logic        wbs_stb_o;
   logic [31:0] wbs_adr_o;
   logic        wbs_we_o;
   logic [31:0] wbs_dat_o;
   logic [3:0]  wbs_sel_o;
   logic [31:0] wbs_dat_i;
   logic        wbs_ack_i;
   logic        wbs_err_i;
   logic [7:0]  cfg_glb_ctrl_o;
   logic [31:0] cfg_clk_ctrl1_o;
   logic [31:0] cfg_clk_ctrl2_o;

   // slave memory model
   logic        slv_ack_q  = 1'b0;
   logic        slv_err_q  = 1'b0;
   logic        slv_open_q = 1'b0;
   logic [1:0]  slv_wait_q = 2'd0;
   logic [31:0] slv_dat_q  = 32'h0;
   logic [31:0] last_adr;
   logic        last_we;
   logic [31:0] last_dat;
   logic [3:0]  last_sel;
   logic [31:0] mem [256];

   // reference model of registers and memory
   logic [31:0] ref_mem [256];
   logic [31:0] ref_glb  = 32'h0;
   logic [7:0]  ref_bank = 8'h30;
   logic [31:0] ref_clk1 = 32'h0;
   logic [31:0] ref_clk2 = 32'h0;

   // bookkeeping
   logic [31:0] lfsr_q = 32'hbf6c_61cf;
   string       test_name;
   int          check_cnt      = 0;
   int          err_cnt        = 0;
   int          test_cnt       = 0;
   int          test_fail_cnt  = 0;
   int          err_at_start   = 0;
   int          afail_at_start = 0;

   always #50 wbm_clk_i = ~wbm_clk_i;

   // slave clock looped back
   assign wbs_clk_i = wbs_clk_o;
   assign wbs_dat_i = slv_dat_q;
   assign wbs_ack_i = slv_ack_q;
   assign wbs_err_i = slv_err_q;

   wbh_top #(
      .SYNC_STAGES (2)
   ) i_wbh_top (.*);

   bind wbh_top wbh_top_asserts i_wbh_top_asserts (.*);

   // --------------------
   // helpers
   // --------------------

   // fibonacci lfsr with taps 32 22 2 1
   // one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         v      = {v[30:0], fb};
      end
      return v;
   endfunction

   // fill depends on the whole word index
   function automatic logic [31:0] fill_word(input logic [7:0] i);
      return {i ^ 8'ha5, ~i, i, i ^ 8'h3c};
   endfunction

   function automatic int assert_fails();
      return i_wbh_top.i_wbh_top_asserts.fail_cnt;
   endfunction

   // expected readback with fields masked at write
   function automatic logic [31:0] reg_expect(input logic [1:0] idx);
      case (idx)
         REG_GLB:  return ref_glb;
         REG_BANK: return {24'h0, ref_bank};
         REG_CLK1: return ref_clk1;
         default:  return ref_clk2;
      endcase
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      check_cnt++;
      assert (act === exp)
      else
      begin
         $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic start_test(input string name);
      test_name      = name;
      err_at_start   = err_cnt;
      afail_at_start = assert_fails();
   endtask

   task automatic end_test();
      int errs;
      errs = (err_cnt - err_at_start) + (assert_fails() - afail_at_start);
      test_cnt++;
      if (errs != 0)
         test_fail_cnt++;
      $display("%-14s %s, %0d errors", test_name, (errs == 0) ? "pass" : "fail", errs);
   endtask

   // --------------------
   // master side
   // --------------------

   // single transfer driven on the falling edge
   // ends on the first sample with ack or err
   task automatic bus_access(input logic [31:0] adr, input logic we, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat,
                             output logic err);
      @(negedge wbm_clk_i);
      wbm_cyc_i = 1'b1;
      wbm_stb_i = 1'b1;
      wbm_adr_i = adr;
      wbm_we_i  = we;
      wbm_dat_i = wdat;
      wbm_sel_i = sel;
      do
         @(negedge wbm_clk_i);
      while (!(wbm_ack_o || wbm_err_o));
      rdat      = wbm_dat_o;
      err       = wbm_err_o;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_we_i  = 1'b0;
   endtask

   // local window has bit 23 set and the index in bits 3:2
   task automatic reg_write(input logic [1:0] idx, input logic [31:0] d);
      logic [31:0] q;
      logic        e;
      bus_access({8'(rand_bits(8)), 1'b1, 19'h0, idx, 2'b00}, 1'b1, d, 4'hf, q, e);
      check_value("reg write err", 32'h0, e);
      case (idx)
         REG_GLB:  ref_glb  = d & 32'h0000_07ff;
         REG_BANK: ref_bank = d[7:0];
         REG_CLK1: ref_clk1 = d;
         default:  ref_clk2 = d;
      endcase
   endtask

   task automatic reg_read_check(input logic [1:0] idx);
      logic [31:0] q;
      logic        e;
      bus_access({8'(rand_bits(8)), 1'b1, 19'h0, idx, 2'b00}, 1'b0, 32'h0, 4'hf, q, e);
      check_value("reg read err", 32'h0, e);
      check_value($sformatf("reg %0d readback", idx), reg_expect(idx), q);
   endtask

   task automatic check_cfg();
      check_value("cfg_glb_ctrl_o", {24'h0, ref_glb[7:0]}, {24'h0, cfg_glb_ctrl_o});
      check_value("cfg_clk_ctrl1_o", ref_clk1, cfg_clk_ctrl1_o);
      check_value("cfg_clk_ctrl2_o", ref_clk2, cfg_clk_ctrl2_o);
   endtask

   // bridged offset with bits 23 and 22 clear
   // top byte is replaced by the bank
   task automatic brg_write(input logic [9:0] ofs, input logic [31:0] d, input logic [3:0] sel);
      logic [31:0] q;
      logic        e;
      bus_access({8'(rand_bits(8)), 14'h0, ofs}, 1'b1, d, sel, q, e);
      check_value("bridge write err", 32'h0, e);
      check_value("slave address", {ref_bank, 14'h0, ofs}, last_adr);
      check_value("slave we", 32'h1, {31'h0, last_we});
      check_value("slave data", d, last_dat);
      check_value("slave sel", {28'h0, sel}, {28'h0, last_sel});
      ref_mem[ofs[9:2]] = d;
   endtask

   task automatic brg_read_check(input logic [9:0] ofs);
      logic [31:0] q;
      logic        e;
      bus_access({8'(rand_bits(8)), 14'h0, ofs}, 1'b0, 32'h0, 4'hf, q, e);
      check_value("bridge read err", 32'h0, e);
      check_value("slave address", {ref_bank, 14'h0, ofs}, last_adr);
      check_value("slave we", 32'h0, {31'h0, last_we});
      check_value("bridge readback", ref_mem[ofs[9:2]], q);
   endtask

   // --------------------
   // slave memory model
   // --------------------

   // 0 to 3 wait states
   // err when address bit 22 is set
   always @(posedge wbs_clk_i)
   begin
      slv_ack_q <= 1'b0;
      slv_err_q <= 1'b0;
      if (wbs_cyc_o && wbs_stb_o && !slv_ack_q && !slv_err_q)
      begin
         if (!slv_open_q)
         begin
            slv_open_q <= 1'b1;
            slv_wait_q <= 2'(rand_bits(2));
         end
         else if (slv_wait_q != 2'd0)
            slv_wait_q <= slv_wait_q - 2'd1;
         else
         begin
            slv_open_q <= 1'b0;
            last_adr   <= wbs_adr_o;
            last_we    <= wbs_we_o;
            last_dat   <= wbs_dat_o;
            last_sel   <= wbs_sel_o;
            if (wbs_adr_o[22])
               slv_err_q <= 1'b1;
            else
            begin
               slv_ack_q <= 1'b1;
               if (wbs_we_o)
                  mem[wbs_adr_o[9:2]] <= wbs_dat_o;
               else
                  slv_dat_q <= mem[wbs_adr_o[9:2]];
            end
         end
      end
   end

   // --------------------
   // watchdog
   // --------------------

   initial
   begin
      repeat (N_TESTS * XFERS_PER_TEST * CYC_PER_XFER) @(posedge wbm_clk_i);
      $display("watchdog expired, the tests did not finish in time");
      $display("TEST FAILED");
      $finish;
   end

   // --------------------
   // tests
   // --------------------

   initial
   begin
      logic [31:0] d;
      logic [31:0] q;
      logic        e;
      logic [9:0]  ofs;
      logic [1:0]  op;
      logic [1:0]  idx;
      realtime     t_rise;
      realtime     t_fall;

      wbm_rst_n = 1'b1;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_adr_i = 32'h0;
      wbm_we_i  = 1'b0;
      wbm_dat_i = 32'h0;
      wbm_sel_i = 4'h0;
      for (int i = 0; i < 256; i++)
      begin
         mem[i]     = fill_word(8'(i));
         ref_mem[i] = fill_word(8'(i));
      end
      // reset low for 10 cycles
      #10;
      wbm_rst_n = 1'b0;
      repeat (10) @(negedge wbm_clk_i);
      wbm_rst_n = 1'b1;

      start_test("reset_values");
      for (int i = 0; i < 4; i++)
         reg_read_check(2'(i));
      check_cfg();
      check_value("wbs_cyc_o idle", 32'h0, {31'h0, wbs_cyc_o});
      // undivided slave clock follows the master clock
      @(posedge wbm_clk_i);
      #25;
      check_value("wbs_clk_o high", 32'h1, {31'h0, wbs_clk_o});
      @(negedge wbm_clk_i);
      #25;
      check_value("wbs_clk_o low", 32'h0, {31'h0, wbs_clk_o});
      end_test();

      start_test("reg_rw");
      for (int n = 0; n < 4; n++)
         for (int i = 0; i < 4; i++)
         begin
            reg_write(2'(i), rand_bits(32));
            reg_read_check(2'(i));
            check_cfg();
         end
      reg_write(REG_GLB, 32'h0);
      end_test();

      start_test("bridge_rw");
      for (int b = 0; b < 2; b++)
      begin
         // reset bank first and then a random one
         reg_write(REG_BANK, (b == 0) ? 32'h30 : rand_bits(8));
         for (int n = 0; n < 8; n++)
         begin
            ofs = 10'(rand_bits(8) << 2);
            brg_write(ofs, rand_bits(32), 4'(rand_bits(4)));
            brg_read_check(ofs);
         end
      end
      end_test();

      start_test("error_path");
      for (int n = 0; n < 4; n++)
      begin
         ofs = 10'(rand_bits(8) << 2);
         bus_access({8'(rand_bits(8)), 2'b01, 12'h0, ofs}, 1'b0, 32'h0, 4'hf, q, e);
         check_value("err flag", 32'h1, {31'h0, e});
         // next transfer must complete normally
         brg_write(ofs, rand_bits(32), 4'hf);
         brg_read_check(ofs);
      end
      end_test();

      start_test("clk_divide");
      for (int r = 0; r < 4; r++)
      begin
         reg_write(REG_GLB, 32'h400 | (r << 8) | rand_bits(8));
         repeat (8) @(negedge wbm_clk_i);
         @(posedge wbs_clk_o);
         t_rise = $realtime;
         @(negedge wbs_clk_o);
         t_fall = $realtime;
         check_value("slave clock high ns", (r + 1) * 100, int'(t_fall - t_rise));
         ofs = 10'(rand_bits(8) << 2);
         brg_write(ofs, rand_bits(32), 4'hf);
         brg_read_check(ofs);
      end
      reg_write(REG_GLB, 32'h0);
      end_test();

      start_test("interleave");
      for (int n = 0; n < 40; n++)
      begin
         op  = 2'(rand_bits(2));
         idx = 2'(rand_bits(2));
         ofs = 10'(rand_bits(8) << 2);
         d   = rand_bits(32);
         case (op)
            2'd0:
            begin
               // divider kept off while mixing
               if (idx == REG_GLB)
                  d[10] = 1'b0;
               reg_write(idx, d);
            end
            2'd1:    reg_read_check(idx);
            2'd2:    brg_write(ofs, d, 4'(rand_bits(4)));
            default: brg_read_check(ofs);
         endcase
      end
      check_cfg();
      end_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               test_cnt, test_fail_cnt, check_cnt, err_cnt, assert_fails());
      if (err_cnt == 0 && assert_fails() == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* src.f */
logic/wbh_pkg.sv
logic/wbh_ctrl_regs.sv
logic/wbh_slave_clk_gen.sv
logic/wbh_async_bridge.sv
logic/wbh_top.sv
dv/wbh_top_asserts.sv
dv/tb_wbh_top.sv

/* Bender.yml */
package:
  name: wbh_top

sources:
  - logic/wbh_pkg.sv
  - logic/wbh_ctrl_regs.sv
  - logic/wbh_slave_clk_gen.sv
  - logic/wbh_async_bridge.sv
  - logic/wbh_top.sv
  - target: test
    files:
      - dv/wbh_top_asserts.sv
      - dv/tb_wbh_top.sv
